// File: bf16_scale_macros.svh
// Constants for the block scale subsystem
// Scale numerator, canonical quiet NaN and block FIFO depth

`ifndef BF16_SCALE_MACROS_SVH
`define BF16_SCALE_MACROS_SVH

// --------------------------------------------------
// Number constants
// --------------------------------------------------

// 127.0 in BF16
// sign 0, exponent 0x85, mantissa 0x7E
`define BF16_SCALE_NUMERATOR 16'h42FE

// Positive quiet NaN, mantissa MSB set
`define BF16_CANON_QNAN 16'h7FC0

// --------------------------------------------------
// Buffering
// --------------------------------------------------

// Entries in the block maximum FIFO
// Power of two, at least 2
`define BF16_SCALE_FIFO_DEPTH 4

`endif

// File: bf16_pkg.sv
// BF16 format package
// Field struct, sign/magnitude struct and the word union over both views
// Classification helpers for NaN, infinity and flushed-to-zero values

`default_nettype none

package bf16_pkg;

        // Sign, biased exponent and stored mantissa
        typedef struct packed {
                logic       sign;
                logic [7:0] exp;
                logic [6:0] mant;
        } bf16_fields_t;

        // Sign plus 15-bit magnitude
        // Magnitudes order correctly as unsigned integers
        typedef struct packed {
                logic        sign;
                logic [14:0] abs;
        } bf16_mag_t;

        // One BF16 word, decoded either way
        typedef union packed {
                bf16_fields_t fld;
                bf16_mag_t    mag;
        } bf16_word_u;

        // --------------------------------------------------
        // Classification
        // --------------------------------------------------

        // Exponent all ones, mantissa nonzero
        function automatic logic bf16_is_nan(input bf16_word_u w);
                return (w.fld.exp == 8'hFF) && (w.fld.mant != 7'h00);
        endfunction

        // Exponent all ones, mantissa zero
        function automatic logic bf16_is_inf(input bf16_word_u w);
                return (w.fld.exp == 8'hFF) && (w.fld.mant == 7'h00);
        endfunction

        // Zero or subnormal, both flushed to zero
        function automatic logic bf16_is_eff_zero(input bf16_word_u w);
                return (w.fld.exp == 8'h00);
        endfunction

endpackage : bf16_pkg

`default_nettype wire

// File: bf16_absmax_tracker.sv
// Block absolute-maximum tracker
// Takes a BF16 sample stream, emits one max magnitude per block
// NaN in a block forces the canonical quiet NaN out

`timescale 1ns/100ps
`default_nettype none

`include "bf16_scale_macros.svh"

module bf16_absmax_tracker (
        input  logic                clk,
        input  logic                rst_n,
        input  bf16_pkg::bf16_word_u sample,
        input  logic                sample_valid,
        input  logic                sample_last,
        output logic                sample_ready,
        output bf16_pkg::bf16_word_u max_data,
        output logic                max_valid,
        input  logic                max_ready
);

        import bf16_pkg::*;

        logic [14:0] run_max;
        logic        nan_seen;
        logic [14:0] smp_abs;
        logic [14:0] blk_max;
        logic        blk_nan;
        logic        smp_fire;

        // Stall input while a finished maximum waits downstream
        assign sample_ready = ~max_valid | max_ready;
        assign smp_fire     = sample_valid & sample_ready;

        // Subnormals count as zero
        assign smp_abs = bf16_is_eff_zero(sample) ? 15'h0000 : sample.mag.abs;
        assign blk_max = (smp_abs > run_max) ? smp_abs : run_max;
        assign blk_nan = nan_seen | bf16_is_nan(sample);

        // --------------------------------------------------
        // Running state
        // --------------------------------------------------
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        run_max  <= 15'h0000;
                        nan_seen <= 1'b0;
                end else if (smp_fire) begin
                        // Last beat restarts the block
                        run_max  <= sample_last ? 15'h0000 : blk_max;
                        nan_seen <= sample_last ? 1'b0 : blk_nan;
                end
        end

        // Output handshake
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        max_valid <= 1'b0;
                end else if (smp_fire && sample_last) begin
                        max_valid <= 1'b1;
                end else if (max_ready) begin
                        max_valid <= 1'b0;
                end
        end

        // Result word, sign always cleared
        always_ff @(posedge clk) begin
                if (smp_fire && sample_last) begin
                        max_data <= blk_nan ? bf16_word_u'(`BF16_CANON_QNAN)
                                            : bf16_word_u'({1'b0, blk_max});
                end
        end

        // Stalled maximum holds until taken
        a_max_hold : assert property (@(posedge clk) disable iff (!rst_n)
                max_valid && !max_ready |=> max_valid && $stable(max_data));

endmodule : bf16_absmax_tracker

`default_nettype wire

// File: bf16_block_fifo.sv
// First-word-fall-through FIFO of block maxima
// Circular buffer with extended pointers, valid/ready on both ports
// A written entry becomes readable one cycle after its write edge

`timescale 1ns/100ps
`default_nettype none

`include "bf16_scale_macros.svh"

module bf16_block_fifo (
        input  logic                clk,
        input  logic                rst_n,
        input  bf16_pkg::bf16_word_u wr_data,
        input  logic                wr_valid,
        output logic                wr_ready,
        output bf16_pkg::bf16_word_u rd_data,
        output logic                rd_valid,
        input  logic                rd_ready
);

        import bf16_pkg::*;

        localparam int DEPTH = `BF16_SCALE_FIFO_DEPTH;
        localparam int AW    = $clog2(DEPTH);

        bf16_word_u    mem [DEPTH];
        logic [AW:0]   wr_ptr;
        logic [AW:0]   wr_ptr_vis;
        logic [AW:0]   rd_ptr;
        logic [AW:0]   fill;
        logic          full;
        logic          empty;
        logic          wr_fire;
        logic          rd_fire;

        // Same index, opposite wrap bit
        assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
        // Read side sees writes one cycle late
        assign empty = (wr_ptr_vis == rd_ptr);

        // Entries held, from the real write pointer
        assign fill = wr_ptr - rd_ptr;

        assign wr_ready = ~full;
        assign rd_valid = ~empty;
        assign wr_fire  = wr_valid & wr_ready;
        assign rd_fire  = rd_valid & rd_ready;

        // Head entry straight out of storage
        assign rd_data = mem[rd_ptr[AW-1:0]];

        // --------------------------------------------------
        // Pointers
        // --------------------------------------------------
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr     <= '0;
                        wr_ptr_vis <= '0;
                        rd_ptr     <= '0;
                end else begin
                        wr_ptr_vis <= wr_ptr;
                        if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
                        if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
                end
        end

        // Storage
        always_ff @(posedge clk) begin
                if (wr_fire) mem[wr_ptr[AW-1:0]] <= wr_data;
        end

        // Writes only land while a slot is free
        a_no_wr_full : assert property (@(posedge clk) disable iff (!rst_n)
                wr_fire |-> fill < DEPTH);

        // Reads only take entries that were written
        a_no_rd_empty : assert property (@(posedge clk) disable iff (!rst_n)
                rd_fire |-> fill != '0);

endmodule : bf16_block_fifo

`default_nettype wire

// File: bf16_scale_divider.sv
// Scale divider, fixed numerator over a block maximum
// Integer significand divide, normalize, RNE round, exponent clamp
// Special cases for NaN, zero and infinity divisors
// Registered result and status flags behind valid/ready

`timescale 1ns/100ps
`default_nettype none

`include "bf16_scale_macros.svh"

module bf16_scale_divider (
        input  logic                clk,
        input  logic                rst_n,
        input  bf16_pkg::bf16_word_u blk_data,
        input  logic                blk_valid,
        output logic                blk_ready,
        output bf16_pkg::bf16_word_u scale,
        output logic                scale_overflow,
        output logic                scale_underflow,
        output logic                scale_div_by_zero,
        output logic                scale_nan,
        output logic                scale_valid,
        input  logic                scale_ready
);

        import bf16_pkg::*;

        bf16_word_u         num;
        logic               res_sign;
        logic [21:0]        dividend_ext;
        logic [7:0]         divisor;
        logic [14:0]        quot;
        logic [7:0]         rem;
        logic               shift_left;
        logic [13:0]        quot_norm;
        logic [6:0]         mant_raw;
        logic               guard;
        logic               round_bit;
        logic               sticky;
        logic               round_up;
        logic [7:0]         mant_rnd;
        logic signed [9:0]  exp_diff;
        logic signed [9:0]  exp_norm;
        logic signed [9:0]  exp_adj;
        logic               exp_ovf;
        logic               exp_unf;
        bf16_word_u         res;
        logic [3:0]         res_flags;
        logic               blk_fire;

        assign num      = bf16_word_u'(`BF16_SCALE_NUMERATOR);
        assign res_sign = num.fld.sign ^ blk_data.fld.sign;

        // --------------------------------------------------
        // Significand divide
        // --------------------------------------------------
        // Quotient has its unit bit at position 14
        assign dividend_ext = {1'b1, num.fld.mant, 14'b0};
        assign divisor      = {1'b1, blk_data.fld.mant};
        assign quot         = 15'(dividend_ext / {14'b0, divisor});
        assign rem          = 8'(dividend_ext % {14'b0, divisor});

        // Quotient lies in (0.5, 2), at most one left shift
        // Hidden bit dropped, fraction lands at [13:0]
        assign shift_left = ~quot[14];
        assign quot_norm  = shift_left ? {quot[12:0], 1'b0} : quot[13:0];

        // Mantissa at [13:7], round bits below
        assign mant_raw  = quot_norm[13:7];
        assign guard     = quot_norm[6];
        assign round_bit = quot_norm[5];
        assign sticky    = (|quot_norm[4:0]) | (rem != 8'h00);

        // Nearest, ties to even
        assign round_up = guard & (round_bit | sticky | mant_raw[0]);
        assign mant_rnd = {1'b0, mant_raw} + {7'b0, round_up};

        // --------------------------------------------------
        // Exponent
        // --------------------------------------------------
        assign exp_diff = $signed({2'b00, num.fld.exp}) - $signed({2'b00, blk_data.fld.exp})
                          + 10'sd127;
        assign exp_norm = shift_left ? exp_diff - 10'sd1 : exp_diff;
        // Mantissa carry bumps the exponent
        assign exp_adj  = mant_rnd[7] ? exp_norm + 10'sd1 : exp_norm;
        assign exp_ovf  = (exp_adj > 10'sd254);
        assign exp_unf  = (exp_adj < 10'sd1);

        // Special cases first, in priority order
        // Flags are {overflow, underflow, div_by_zero, nan}
        always_comb begin
                res       = bf16_word_u'({res_sign, exp_adj[7:0], mant_rnd[6:0]});
                res_flags = 4'b0000;
                if (bf16_is_nan(blk_data)) begin
                        res       = bf16_word_u'(`BF16_CANON_QNAN);
                        res_flags = 4'b0001;
                end else if (bf16_is_eff_zero(blk_data)) begin
                        res       = bf16_word_u'({res_sign, 8'hFF, 7'h00});
                        res_flags = 4'b0010;
                end else if (bf16_is_inf(blk_data)) begin
                        res       = bf16_word_u'({res_sign, 15'h0000});
                end else if (exp_ovf) begin
                        res       = bf16_word_u'({res_sign, 8'hFF, 7'h00});
                        res_flags = 4'b1000;
                end else if (exp_unf) begin
                        res       = bf16_word_u'({res_sign, 15'h0000});
                        res_flags = 4'b0100;
                end
        end

        // --------------------------------------------------
        // Output register
        // --------------------------------------------------
        assign blk_ready = ~scale_valid | scale_ready;
        assign blk_fire  = blk_valid & blk_ready;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        scale_valid <= 1'b0;
                end else if (blk_fire) begin
                        scale_valid <= 1'b1;
                end else if (scale_ready) begin
                        scale_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (blk_fire) begin
                        scale <= res;
                        {scale_overflow, scale_underflow, scale_div_by_zero, scale_nan}
                                <= res_flags;
                end
        end

        // Stalled result and flags hold until taken
        a_out_hold : assert property (@(posedge clk) disable iff (!rst_n)
                scale_valid && !scale_ready |=> scale_valid && $stable(scale)
                && $stable({scale_overflow, scale_underflow, scale_div_by_zero, scale_nan}));

endmodule : bf16_scale_divider

`default_nettype wire

// File: bf16_scale_unit.sv
// Block scale unit top level
// Absmax tracker into block FIFO into scale divider

`timescale 1ns/100ps
`default_nettype none

module bf16_scale_unit (
        input  logic                clk,
        input  logic                rst_n,
        input  bf16_pkg::bf16_word_u sample,
        input  logic                sample_valid,
        input  logic                sample_last,
        output logic                sample_ready,
        output bf16_pkg::bf16_word_u scale,
        output logic                scale_overflow,
        output logic                scale_underflow,
        output logic                scale_div_by_zero,
        output logic                scale_nan,
        output logic                scale_valid,
        input  logic                scale_ready
);

        import bf16_pkg::*;

        // Tracker to FIFO
        bf16_word_u max_data;
        logic       max_valid;
        logic       max_ready;

        // FIFO to divider
        bf16_word_u blk_data;
        logic       blk_valid;
        logic       blk_ready;

        // --------------------------------------------------
        // Pipeline
        // --------------------------------------------------
        bf16_absmax_tracker u_absmax (
                .clk          (clk),
                .rst_n        (rst_n),
                .sample       (sample),
                .sample_valid (sample_valid),
                .sample_last  (sample_last),
                .sample_ready (sample_ready),
                .max_data     (max_data),
                .max_valid    (max_valid),
                .max_ready    (max_ready)
        );

        bf16_block_fifo u_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_data  (max_data),
                .wr_valid (max_valid),
                .wr_ready (max_ready),
                .rd_data  (blk_data),
                .rd_valid (blk_valid),
                .rd_ready (blk_ready)
        );

        bf16_scale_divider u_div (
                .clk               (clk),
                .rst_n             (rst_n),
                .blk_data          (blk_data),
                .blk_valid         (blk_valid),
                .blk_ready         (blk_ready),
                .scale             (scale),
                .scale_overflow    (scale_overflow),
                .scale_underflow   (scale_underflow),
                .scale_div_by_zero (scale_div_by_zero),
                .scale_nan         (scale_nan),
                .scale_valid       (scale_valid),
                .scale_ready       (scale_ready)
        );

endmodule : bf16_scale_unit

`default_nettype wire

// File: tb_bf16_scale_unit.sv
// Directed testbench for the BF16 block scale unit
// Clock, reset, sample driver and scale checker tasks
// Tests for normal scales, special values, range limits and latency
// LFSR back-pressure on the scale output with ordering check

`timescale 1ns/100ps
`default_nettype none

module tb_bf16_scale_unit;

        localparam int TIMEOUT = 200;

        logic        clk;
        logic        rst_n;
        logic [15:0] sample;
        logic        sample_valid;
        logic        sample_last;
        logic        sample_ready;
        logic [15:0] scale;
        logic        scale_overflow;
        logic        scale_underflow;
        logic        scale_div_by_zero;
        logic        scale_nan;
        logic        scale_valid;
        logic        scale_ready;

        // Samples of the next block, last flag goes on the final one
        logic [15:0] blk_words [$];
        logic [31:0] lfsr_state;
        logic        rx_done;

        bf16_scale_unit dut0 (
                .clk               (clk),
                .rst_n             (rst_n),
                .sample            (sample),
                .sample_valid      (sample_valid),
                .sample_last       (sample_last),
                .sample_ready      (sample_ready),
                .scale             (scale),
                .scale_overflow    (scale_overflow),
                .scale_underflow   (scale_underflow),
                .scale_div_by_zero (scale_div_by_zero),
                .scale_nan         (scale_nan),
                .scale_valid       (scale_valid),
                .scale_ready       (scale_ready)
        );

        // 4 ns clock
        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // --------------------------------------------------
        // Helpers
        // --------------------------------------------------

        // Fibonacci LFSR, taps 32 22 2 1, one step per bit
        function automatic logic lfsr_next_bit();
                logic fb;
                fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
                lfsr_state = {lfsr_state[30:0], fb};
                return fb;
        endfunction

        task automatic abort_run(input string why);
                $display("%s at %0t ns", why, $time);
                $display("ERRORS FOUND");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input logic [15:0] got, input logic [15:0] want,
                                   input string what);
                if (got !== want) begin
                        $display("mismatch at %0t ns: %s, got 0x%04h, expected 0x%04h",
                                 $time, what, got, want);
                        $display("ERRORS FOUND");
                        $fatal(1, "first mismatch stops the run");
                end
        endtask

        // Drives the queued samples, one beat per accepted transfer
        // Starts and ends 1 ns after a rising edge
        task automatic send_block();
                int waited;
                while (blk_words.size() > 0) begin
                        sample       = blk_words.pop_front();
                        sample_valid = 1'b1;
                        sample_last  = (blk_words.size() == 0);
                        waited       = 0;
                        @(negedge clk);
                        while (!sample_ready) begin
                                waited++;
                                if (waited > TIMEOUT)
                                        abort_run("sample_ready stayed low too long");
                                @(negedge clk);
                        end
                        @(posedge clk);
                        #1;
                end
                sample_valid = 1'b0;
                sample_last  = 1'b0;
        endtask

        // Waits for one scale transfer, flags are {ovf, unf, dbz, nan}
        task automatic expect_scale(input logic [15:0] want, input logic [3:0] want_flags,
                                    input string what);
                int waited;
                waited = 0;
                @(negedge clk);
                while (!(scale_valid && scale_ready)) begin
                        waited++;
                        if (waited > TIMEOUT)
                                abort_run({"no scale result arrived for ", what});
                        @(negedge clk);
                end
                check_value(scale, want, {what, " value"});
                check_value({12'h000, scale_overflow, scale_underflow, scale_div_by_zero,
                             scale_nan}, {12'h000, want_flags}, {what, " flags"});
                @(posedge clk);
                #1;
        endtask

        // --------------------------------------------------
        // Tests
        // --------------------------------------------------

        task automatic test_normal_scales();
                // -1.0 is the largest magnitude
                blk_words = '{16'hBF80, 16'h3F00, 16'h0000};
                send_block();
                expect_scale(16'h42FE, 4'b0000, "max 1.0");
                blk_words = '{16'h3F80, 16'hC000, 16'hBF00};
                send_block();
                expect_scale(16'h427E, 4'b0000, "max 2.0");
                blk_words = '{16'hC2FE, 16'h4000};
                send_block();
                expect_scale(16'h3F80, 4'b0000, "max 127.0");
                // 42.33 rounds down to 42.25
                blk_words = '{16'h4040, 16'hBFC0};
                send_block();
                expect_scale(16'h4229, 4'b0000, "max 3.0");
        endtask

        task automatic test_zero_block();
                // Zeros of both signs plus subnormals
                blk_words = '{16'h0000, 16'h8000, 16'h0001, 16'h807F};
                send_block();
                expect_scale(16'h7F80, 4'b0010, "zero block");
        endtask

        task automatic test_nan_inf();
                // NaN beats the large finite value
                blk_words = '{16'h7F7F, 16'h3F80, 16'hFFC1, 16'hC2FE};
                send_block();
                expect_scale(16'h7FC0, 4'b0001, "nan block");
                blk_words = '{16'h3F80, 16'hFF80, 16'h4000};
                send_block();
                expect_scale(16'h0000, 4'b0000, "inf block");
        endtask

        task automatic test_range_limits();
                blk_words = '{16'h0080, 16'h8001};
                send_block();
                expect_scale(16'h7F80, 4'b1000, "smallest normal");
                // 127 over the largest finite value is about 3.75e-37, still normal
                blk_words = '{16'hFF7F, 16'h3F80};
                send_block();
                expect_scale(16'h02FF, 4'b0000, "largest finite");
        endtask

        task automatic test_latency();
                int edges;
                scale_ready = 1'b1;
                blk_words   = '{16'hBF80};
                send_block();
                // Count edges after the one that took the last sample
                edges = 0;
                @(negedge clk);
                while (!scale_valid) begin
                        edges++;
                        if (edges > TIMEOUT)
                                abort_run("scale_valid never rose in the latency test");
                        @(negedge clk);
                end
                check_value(16'(edges), 16'd3, "latency in cycles");
                check_value(scale, 16'h42FE, "latency block value");
                @(posedge clk);
                #1;
        endtask

        // Block maxima for the back-pressure run
        function automatic logic [15:0] bp_max_word(input int i);
                case (i)
                        0:       return 16'h3F80;
                        1:       return 16'h4000;
                        2:       return 16'h42FE;
                        3:       return 16'h4040;
                        4:       return 16'h0080;
                        5:       return 16'h7F80;
                        6:       return 16'h0000;
                        default: return 16'h7FC0;
                endcase
        endfunction

        // {flags, scale} for each of those maxima
        function automatic logic [19:0] bp_expect(input int i);
                case (i)
                        0:       return {4'b0000, 16'h42FE};
                        1:       return {4'b0000, 16'h427E};
                        2:       return {4'b0000, 16'h3F80};
                        3:       return {4'b0000, 16'h4229};
                        4:       return {4'b1000, 16'h7F80};
                        5:       return {4'b0000, 16'h0000};
                        6:       return {4'b0010, 16'h7F80};
                        default: return {4'b0001, 16'h7FC0};
                endcase
        endfunction

        task automatic test_backpressure();
                rx_done     = 1'b0;
                scale_ready = lfsr_next_bit();
                fork
                        begin
                                for (int i = 0; i < 8; i++) begin
                                        // Odd blocks carry a negative maximum
                                        blk_words = '{16'h8001,
                                                      bp_max_word(i) | (i[0] ? 16'h8000 : 16'h0)};
                                        send_block();
                                end
                        end
                        begin
                                logic [19:0] exp_res;
                                for (int i = 0; i < 8; i++) begin
                                        exp_res = bp_expect(i);
                                        expect_scale(exp_res[15:0], exp_res[19:16],
                                                     $sformatf("block %0d", i));
                                end
                                rx_done = 1'b1;
                        end
                        begin
                                int cycles;
                                cycles = 0;
                                while (!rx_done) begin
                                        cycles++;
                                        if (cycles > 8 * TIMEOUT)
                                                abort_run("back-pressure run never finished");
                                        @(posedge clk);
                                        #1;
                                        scale_ready = lfsr_next_bit();
                                end
                        end
                join
                scale_ready = 1'b1;
                // Nothing left over once all eight are out
                repeat (8) begin
                        @(negedge clk);
                        check_value({15'h0, scale_valid}, 16'h0000, "extra scale result");
                end
                @(posedge clk);
                #1;
        endtask

        // --------------------------------------------------
        // Main sequence
        // --------------------------------------------------
        initial begin
                rst_n        = 1'b0;
                sample       = 16'h0000;
                sample_valid = 1'b0;
                sample_last  = 1'b0;
                scale_ready  = 1'b1;
                rx_done      = 1'b0;
                lfsr_state   = 32'h6142;
                repeat (5) @(posedge clk);
                #1;
                rst_n = 1'b1;
                @(posedge clk);
                #1;
                check_value({15'h0, sample_ready}, 16'h0001, "sample_ready after reset");
                test_normal_scales();
                test_zero_block();
                test_nan_inf();
                test_range_limits();
                test_latency();
                test_backpressure();
                $display("NO ERRORS");
                $finish;
        end

endmodule : tb_bf16_scale_unit

`default_nettype wire

// File: bf16_scale_unit.f
+incdir+.
bf16_pkg.sv
bf16_absmax_tracker.sv
bf16_block_fifo.sv
bf16_scale_divider.sv
bf16_scale_unit.sv
tb_bf16_scale_unit.sv

// File: Bender.yml
package:
  name: bf16_scale_unit

export_include_dirs:
  - .

sources:
  # bf16_scale_macros.svh is picked up through the include directory
  - include_dirs:
      - .
    files:
      - bf16_pkg.sv
      - bf16_absmax_tracker.sv
      - bf16_block_fifo.sv
      - bf16_scale_divider.sv
      - bf16_scale_unit.sv
  - target: simulation
    files:
      - tb_bf16_scale_unit.sv
